// ==== hdl/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// byte address seen by the directory
`define CACHE_ADDR_W    16
`define CACHE_OFFSET_W  2   // bytes per line as a power of two

// cache geometry
`define CACHE_N_SETS    8
`define CACHE_N_WAYS    4
`define CACHE_INDEX_W   3   // log2 of the set count
`define CACHE_NWAY_W    2   // log2 of the way count

// whatever is left of the address above offset and index is the tag
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_OFFSET_W - `CACHE_INDEX_W)

// replacement policy codes
`define CACHE_LRU        0  // true LRU with a rank per way
`define CACHE_PLRU_MRU   1  // pseudo LRU built from one MRU bit per way
`define CACHE_PLRU_TREE  2  // pseudo LRU built from a binary tree of node bits

// policy built into the directory
`define CACHE_REP_POLICY `CACHE_LRU

`endif

// ==== hdl/cache_pkg.sv ====
`include "cache_settings.svh"

package cache_pkg;

   typedef logic [`CACHE_TAG_W-1:0]   tag_t;     // tag field of an address
   typedef logic [`CACHE_INDEX_W-1:0] index_t;   // set index field of an address
   typedef logic [`CACHE_N_WAYS-1:0]  way_oh_t;  // one bit per way
   typedef logic [`CACHE_NWAY_W-1:0]  way_idx_t; // binary way number

   // one directory entry, the valid bit sits above the tag
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   typedef tag_entry_t [`CACHE_N_WAYS-1:0] tag_set_t; // all ways of a set, way 0 in the low bits

   // policy state of one set, one type per policy
   typedef logic [`CACHE_N_WAYS-1:0][`CACHE_NWAY_W-1:0] lru_state_t; // rank per way, 0 is oldest
   typedef logic [`CACHE_N_WAYS-1:0] mru_state_t;    // set when the way was used recently
   typedef logic [`CACHE_N_WAYS-1:1] tree_state_t;   // node 1 is the root of the tree

   // binary number of the set bit in a one-hot way vector
   // the set bit indices are ORed so an all-zero vector gives way 0
   function automatic way_idx_t onehot_to_idx(input way_oh_t oh);
      way_idx_t idx;
      idx = '0;
      for (int i = 0; i < `CACHE_N_WAYS; i++)
      begin
         if (oh[i])
            idx = idx | way_idx_t'(i);
      end
      return idx;
   endfunction

endpackage

// ==== hdl/set_state_ram.sv ====
`timescale 1ns/1ps

// small register file with one entry per set
// read is combinational so a write at the end of one lookup is seen by the next lookup
module set_state_ram
  #(
    parameter type T         = logic,                           // payload stored per set
    parameter int  N_ENTRIES = 2**$bits(cache_pkg::index_t)     // one entry per set by default
    )
   (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we,     // write strobe, one per lookup
    input  cache_pkg::index_t addr,   // set being read and written
    input  T                  wdata,
    output T                  rdata
    );

   T mem [N_ENTRIES]; // the entries themselves

   // the whole array is cleared by reset so all entries start invalid
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < N_ENTRIES; i++)
            mem[i] <= '0;
      end
      else if (we)
      begin
         mem[addr] <= wdata; // new value visible from the next cycle
      end
   end

   assign rdata = mem[addr]; // asynchronous read of the addressed set

endmodule

// ==== hdl/addr_decode.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

// decode stage
// the request strobe is registered and the address is split into index and tag
module addr_decode
   (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,          // one cycle request strobe
    input  logic [`CACHE_ADDR_W-1:0] addr,         // byte address, sampled with req
    output logic                     lookup_valid, // lookup in progress this cycle
    output cache_pkg::index_t        lookup_index, // set to look at
    output cache_pkg::tag_t          lookup_tag    // tag to compare against the set
    );

   cache_pkg::index_t addr_index; // index field just above the line offset
   cache_pkg::tag_t   addr_tag;   // everything above the index

   // the offset bits select a byte inside the line and take no part in the lookup
   assign addr_index = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
   assign addr_tag   = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

   // strobe register
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         lookup_valid <= 1'b0;
      else
         lookup_valid <= req; // one cycle in, one cycle out
   end

   // address fields are only loaded with a request and hold otherwise
   always_ff @(posedge clk)
   begin
      if (req)
      begin
         lookup_index <= addr_index;
         lookup_tag   <= addr_tag;
      end
   end

endmodule

// ==== hdl/tag_lookup.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

// execute stage
// compares the tag against every way of the set and fills the victim way on a miss
module tag_lookup
   (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lookup_valid, // lookup strobe from decode
    input  cache_pkg::index_t   lookup_index,
    input  cache_pkg::tag_t     lookup_tag,
    input  cache_pkg::way_oh_t  victim_way,   // way the policy gives up on a miss
    output cache_pkg::way_oh_t  access_way,   // way touched by this lookup, to the policy
    output logic                hit,
    output cache_pkg::way_idx_t way,          // binary number of access_way
    output logic                evict_valid,  // a valid tag is pushed out of the victim way
    output cache_pkg::tag_t     evict_tag
    );

   cache_pkg::tag_set_t   rd_set;       // tags of the addressed set
   cache_pkg::tag_set_t   fill_set;     // same set after the fill
   cache_pkg::way_oh_t    hit_vec;      // one bit per matching way
   cache_pkg::tag_entry_t victim_entry; // entry currently held in the victim way
   logic                  hit_any;

   // tag array, written at the edge that closes each lookup
   set_state_ram
     #(
       .T         (cache_pkg::tag_set_t),
       .N_ENTRIES (`CACHE_N_SETS)
       )
   u_tag_ram
     (
      .clk   (clk),
      .rst_n (rst_n),
      .we    (lookup_valid),
      .addr  (lookup_index),
      .wdata (fill_set),
      .rdata (rd_set)
      );

   // a way matches when it holds a valid copy of the tag
   always_comb
   begin
      for (int i = 0; i < `CACHE_N_WAYS; i++)
         hit_vec[i] = rd_set[i].valid && (rd_set[i].tag == lookup_tag);
   end

   assign hit_any      = |hit_vec;
   assign victim_entry = rd_set[cache_pkg::onehot_to_idx(victim_way)];

   // on a miss the victim way gets the new tag, a hit writes the set back unchanged
   always_comb
   begin
      fill_set = rd_set;
      for (int i = 0; i < `CACHE_N_WAYS; i++)
      begin
         if (!hit_any && victim_way[i])
         begin
            fill_set[i].valid = 1'b1;
            fill_set[i].tag   = lookup_tag;
         end
      end
   end

   // every output is quiet outside a lookup cycle
   assign access_way  = !lookup_valid ? '0 : (hit_any ? hit_vec : victim_way);
   assign hit         = lookup_valid && hit_any;
   assign way         = cache_pkg::onehot_to_idx(access_way);
   assign evict_valid = lookup_valid && !hit_any && victim_entry.valid;
   assign evict_tag   = evict_valid ? victim_entry.tag : '0; // old tag only when it was live

   // fills only go to ways that missed so a tag can never sit twice in a set
   a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      lookup_valid |-> $onehot0(hit_vec))
      else $error("tag found in more than one way of set %0d", lookup_index);

endmodule

// ==== hdl/replacement_policy.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

// result stage
// keeps the policy state of each set, names the victim way and updates the state on access
module replacement_policy
  #(
    parameter int REP_POLICY = `CACHE_LRU,    // one of the CACHE_* policy codes
    parameter int N_WAYS     = `CACHE_N_WAYS  // any power of two
    )
   (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               write_en,   // state update strobe, one per lookup
    input  cache_pkg::way_oh_t way_hit,    // way that was accessed
    input  cache_pkg::index_t  line_addr,  // set whose state is used
    output cache_pkg::way_oh_t way_select  // victim way for a miss
    );

   localparam int NWAY_W = $clog2(N_WAYS);

   generate
      if (REP_POLICY == `CACHE_LRU)
      begin : g_lru
         cache_pkg::lru_state_t           state_q, state_d;
         logic [N_WAYS-1:0][NWAY_W-1:0]   rank_cur; // ranks after the all-zero default
         logic [NWAY_W-1:0]               hit_rank; // old rank of the accessed way

         always_comb
         begin
            hit_rank = '0;
            for (int i = 0; i < N_WAYS; i++)
               rank_cur[i] = (|state_q) ? state_q[i] : NWAY_W'(i); // untouched set ranks by way number
            for (int i = 0; i < N_WAYS; i++)
            begin
               if (way_hit[i])
                  hit_rank = hit_rank | rank_cur[i];
            end
            for (int i = 0; i < N_WAYS; i++)
            begin
               way_select[i] = (rank_cur[i] == '0); // rank 0 is the oldest way
               if (way_hit[i])
                  state_d[i] = '1;                  // accessed way becomes the newest
               else if (rank_cur[i] > hit_rank)
                  state_d[i] = rank_cur[i] - 1'b1;  // newer ways slide down one place
               else
                  state_d[i] = rank_cur[i];
            end
            if (!(|way_hit))
               state_d = state_q; // no access leaves the ranks alone
         end

         set_state_ram #(.T(cache_pkg::lru_state_t), .N_ENTRIES(`CACHE_N_SETS)) u_state_ram
           (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (write_en),
            .addr  (line_addr),
            .wdata (state_d),
            .rdata (state_q)
            );
      end
      else if (REP_POLICY == `CACHE_PLRU_MRU)
      begin : g_plru_mru
         cache_pkg::mru_state_t state_q, state_d;

         // when the access would mark every way recent only the access bit is kept
         assign state_d = (&(state_q | way_hit)) ? way_hit : (state_q | way_hit);

         always_comb
         begin
            logic lower_set; // every lower way is marked recent
            lower_set = 1'b1;
            for (int i = 0; i < N_WAYS; i++)
            begin
               way_select[i] = !state_q[i] && lower_set; // lowest clear bit wins
               lower_set     = lower_set && state_q[i];
            end
         end

         set_state_ram #(.T(cache_pkg::mru_state_t), .N_ENTRIES(`CACHE_N_SETS)) u_state_ram
           (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (write_en),
            .addr  (line_addr),
            .wdata (state_d),
            .rdata (state_q)
            );
      end
      else
      begin : g_plru_tree
         cache_pkg::tree_state_t state_q, state_d;

         // walk from the root, a 0 node goes left and a 1 node goes right
         always_comb
         begin
            int node;
            node = 1;
            for (int l = 0; l < NWAY_W; l++)
               node = 2 * node + int'(state_q[node]);
            way_select = '0;
            way_select[node - N_WAYS] = 1'b1; // leaves N_WAYS and up map onto the ways
         end

         // nodes on the path of the accessed way are turned to point away from it
         always_comb
         begin
            int   n;
            int   span;      // ways under each child of node n
            int   left_base; // first way under the left child
            logic hit_l;
            logic hit_r;
            state_d = state_q;
            for (int l = 1; l <= NWAY_W; l++)
            begin
               for (int j = 0; j < (1 << (l - 1)); j++)
               begin
                  n         = (1 << (l - 1)) + j;
                  span      = N_WAYS >> l;
                  left_base = 2 * n * span - N_WAYS;
                  hit_l     = 1'b0;
                  hit_r     = 1'b0;
                  for (int w = 0; w < N_WAYS; w++)
                  begin
                     if (way_hit[w] && (w >= left_base) && (w < left_base + span))
                        hit_l = 1'b1;
                     if (way_hit[w] && (w >= left_base + span) && (w < left_base + 2 * span))
                        hit_r = 1'b1;
                  end
                  if (hit_l)
                     state_d[n] = 1'b1;
                  else if (hit_r)
                     state_d[n] = 1'b0;
               end
            end
         end

         set_state_ram #(.T(cache_pkg::tree_state_t), .N_ENTRIES(`CACHE_N_SETS)) u_state_ram
           (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (write_en),
            .addr  (line_addr),
            .wdata (state_d),
            .rdata (state_q)
            );
      end
   endgenerate

   a_access_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      write_en |-> $onehot0(way_hit))
      else $error("policy update with more than one accessed way");

   // holds only while the stored state stays legal from one update to the next
   // the victim is only used in a lookup cycle, the set index is undefined before the first one
   a_victim_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      write_en |-> $onehot(way_select))
      else $error("policy names %b as victim for set %0d", way_select, line_addr);

endmodule

// ==== hdl/cache_directory.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

// tag directory of the set-associative cache
// decode registers the request, lookup and policy answer in the next cycle
module cache_directory
   (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,         // one cycle request strobe
    input  logic [`CACHE_ADDR_W-1:0] addr,
    output logic                     resp_valid,  // one cycle response strobe
    output logic                     hit,
    output cache_pkg::way_idx_t      way,
    output logic                     evict_valid,
    output cache_pkg::tag_t          evict_tag
    );

   logic               lookup_valid;
   cache_pkg::index_t  lookup_index;
   cache_pkg::tag_t    lookup_tag;
   cache_pkg::way_oh_t access_way;  // lookup to policy
   cache_pkg::way_oh_t victim_way;  // policy back to lookup

   addr_decode u_decode
     (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req),
      .addr         (addr),
      .lookup_valid (lookup_valid),
      .lookup_index (lookup_index),
      .lookup_tag   (lookup_tag)
      );

   tag_lookup u_lookup
     (
      .clk          (clk),
      .rst_n        (rst_n),
      .lookup_valid (lookup_valid),
      .lookup_index (lookup_index),
      .lookup_tag   (lookup_tag),
      .victim_way   (victim_way),
      .access_way   (access_way),
      .hit          (hit),
      .way          (way),
      .evict_valid  (evict_valid),
      .evict_tag    (evict_tag)
      );

   replacement_policy
     #(
       .REP_POLICY (`CACHE_REP_POLICY),
       .N_WAYS     (`CACHE_N_WAYS)
       )
   u_policy
     (
      .clk        (clk),
      .rst_n      (rst_n),
      .write_en   (lookup_valid), // both state memories update at the same edge
      .way_hit    (access_way),
      .line_addr  (lookup_index),
      .way_select (victim_way)
      );

   assign resp_valid = lookup_valid; // the response leaves in the lookup cycle itself

endmodule

// ==== tests/cache_directory_tb.sv ====
`timescale 1ns/1ps
`include "cache_settings.svh"

// directed testbench for the cache tag directory with an LRU reference model
module cache_directory_tb;

   localparam int RESP_TIMEOUT = 16;           // cycles allowed between request and response
   localparam int N_RANDOM     = 200;          // requests in the random traffic test
   localparam int N_SETS       = `CACHE_N_SETS;
   localparam int N_WAYS       = `CACHE_N_WAYS;

   logic                     clk;
   logic                     rst_n;
   logic                     req;
   logic [`CACHE_ADDR_W-1:0] addr;
   logic                     resp_valid;
   logic                     hit;
   cache_pkg::way_idx_t      way;
   logic                     evict_valid;
   cache_pkg::tag_t          evict_tag;

   // reference model of the directory, one entry per set and way
   logic            model_valid [N_SETS][N_WAYS];
   cache_pkg::tag_t model_tag   [N_SETS][N_WAYS];
   int              model_rank  [N_SETS][N_WAYS]; // 0 is the least recently used way

   cache_directory u_dut
     (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .addr        (addr),
      .resp_valid  (resp_valid),
      .hit         (hit),
      .way         (way),
      .evict_valid (evict_valid),
      .evict_tag   (evict_tag)
      );

   always
   begin
      #10 clk = ~clk; // 20 ns period
   end

   // builds a byte address from its tag, set and offset fields
   function automatic logic [`CACHE_ADDR_W-1:0] make_addr(input int tag, input int set,
                                                          input int offset);
      logic [`CACHE_OFFSET_W-1:0] off_bits;
      off_bits  = offset[`CACHE_OFFSET_W-1:0];
      make_addr = {cache_pkg::tag_t'(tag), cache_pkg::index_t'(set), off_bits};
   endfunction

   task automatic check_value(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
         $display("SIMULATION FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic model_reset;
      for (int s = 0; s < N_SETS; s++)
      begin
         for (int w = 0; w < N_WAYS; w++)
         begin
            model_valid[s][w] = 1'b0;
            model_tag[s][w]   = '0;
            model_rank[s][w]  = w; // a fresh set ranks its ways by way number
         end
      end
   endtask

   // predicts one access and moves the model to the state after it
   task automatic model_access(input logic [`CACHE_ADDR_W-1:0] a, output logic exp_hit,
                               output int exp_way, output logic exp_ev,
                               output cache_pkg::tag_t exp_tag);
      int              set;
      int              w;
      int              old_rank;
      cache_pkg::tag_t tag;
      set     = int'(a[`CACHE_OFFSET_W +: `CACHE_INDEX_W]);
      tag     = a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
      w       = -1;
      exp_ev  = 1'b0;
      exp_tag = '0;
      for (int i = 0; i < N_WAYS; i++)
      begin
         if (model_valid[set][i] && (model_tag[set][i] == tag))
            w = i;
      end
      exp_hit = (w >= 0);
      if (!exp_hit)
      begin
         for (int i = 0; i < N_WAYS; i++)
         begin
            if (model_rank[set][i] == 0)
               w = i; // the oldest way is the victim
         end
         exp_ev            = model_valid[set][w];
         exp_tag           = model_tag[set][w];
         model_valid[set][w] = 1'b1;
         model_tag[set][w]   = tag;
      end
      old_rank = model_rank[set][w];
      for (int i = 0; i < N_WAYS; i++)
      begin
         if (model_rank[set][i] > old_rank)
            model_rank[set][i]--; // newer ways slide down one place
      end
      model_rank[set][w] = N_WAYS - 1; // accessed way becomes the newest
      exp_way = w;
   endtask

   // compares the response on the bus with the model for the address
   task automatic check_response(input logic [`CACHE_ADDR_W-1:0] a);
      logic            exp_hit;
      logic            exp_ev;
      int              exp_way;
      cache_pkg::tag_t exp_tag;
      model_access(a, exp_hit, exp_way, exp_ev, exp_tag);
      check_value($sformatf("hit for address %h", a), hit, exp_hit);
      check_value($sformatf("way for address %h", a), way, exp_way);
      check_value($sformatf("evict_valid for address %h", a), evict_valid, exp_ev);
      if (exp_ev)
         check_value($sformatf("evict_tag for address %h", a), evict_tag, exp_tag);
   endtask

   task automatic apply_reset;
      rst_n = 1'b0;
      req   = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      model_reset();
   endtask

   // one request, then a bounded wait for its response, ends on the negedge that shows it
   task automatic access(input logic [`CACHE_ADDR_W-1:0] a);
      int cycles;
      req  = 1'b1;
      addr = a;
      @(negedge clk);
      req    = 1'b0;
      cycles = 0;
      while (!resp_valid)
      begin
         if (cycles >= RESP_TIMEOUT)
         begin
            $display("no response within %0d cycles of the request for %h", RESP_TIMEOUT, a);
            $display("SIMULATION FAILED");
            $fatal(1, "response timeout");
         end
         cycles++;
         @(negedge clk);
      end
      check_response(a);
   endtask

   task automatic test_reset_state;
      apply_reset();
      repeat (3)
      begin
         check_value("resp_valid after reset", resp_valid, 1'b0);
         check_value("evict_valid after reset", evict_valid, 1'b0);
         @(negedge clk);
      end
      for (int s = 0; s < N_SETS; s++)
      begin
         access(make_addr(s + 1, s, s % 4));
         check_value("first access hit", hit, 1'b0);   // every set starts empty
         check_value("first access way", way, 0);
         check_value("first access evict_valid", evict_valid, 1'b0);
      end
   endtask

   task automatic test_repeat_hit;
      for (int s = 0; s < N_SETS; s++)
      begin
         access(make_addr(s + 1, s, (s + 1) % 4)); // other offset, same line
         check_value("repeat hit", hit, 1'b1);
         check_value("repeat way", way, 0);
         check_value("repeat evict_valid", evict_valid, 1'b0);
      end
   endtask

   task automatic test_fill_and_evict;
      apply_reset();
      for (int i = 0; i < N_WAYS; i++)
      begin
         access(make_addr('h10 + i, 3, 0));
         check_value("fill way order", way, i);
         check_value("fill evict_valid", evict_valid, 1'b0);
      end
      access(make_addr('h14, 3, 0));
      check_value("fifth tag way", way, 0);      // way 0 holds the oldest tag
      check_value("fifth tag evict_valid", evict_valid, 1'b1);
      check_value("fifth tag evict_tag", evict_tag, 'h10);
   endtask

   task automatic test_hit_spares_way;
      apply_reset();
      for (int i = 0; i < N_WAYS; i++)
         access(make_addr('h20 + i, 6, 1));
      access(make_addr('h20, 6, 2)); // refreshes the oldest way
      check_value("hit on oldest way", hit, 1'b1);
      access(make_addr('h24, 6, 3));
      check_value("victim after hit", way, 1); // way 1 is now the oldest
      check_value("evicted tag after hit", evict_tag, 'h21);
   endtask

   // a request on every cycle, each response checked on the very next negedge
   task automatic test_back_to_back;
      logic [`CACHE_ADDR_W-1:0] seq[$];
      apply_reset();
      seq = '{make_addr(1, 2, 0), make_addr(2, 2, 1), make_addr(1, 2, 2), make_addr(3, 2, 3),
              make_addr(4, 2, 0), make_addr(5, 2, 1), make_addr(7, 5, 0), make_addr(2, 2, 2),
              make_addr(7, 5, 3), make_addr(9, 0, 1)};
      for (int i = 0; i <= seq.size(); i++)
      begin
         if (i > 0)
         begin
            check_value("resp_valid one cycle after request", resp_valid, 1'b1);
            check_response(seq[i-1]);
         end
         if (i < seq.size())
         begin
            req  = 1'b1;
            addr = seq[i];
         end
         else
            req = 1'b0;
         @(negedge clk);
      end
      check_value("resp_valid after the last response", resp_valid, 1'b0);
   endtask

   task automatic test_random_traffic;
      apply_reset();
      for (int n = 0; n < N_RANDOM; n++)
      begin
         // three sets and six tags keep both hits and evictions frequent
         access(make_addr($urandom_range(5, 0), $urandom_range(2, 0), $urandom_range(3, 0)));
         if ($urandom_range(3, 0) == 0)
            @(negedge clk); // idle cycle now and then
      end
   endtask

   initial
   begin
      clk   = 1'b0;
      rst_n = 1'b0;
      req   = 1'b0;
      addr  = '0;
      void'($urandom(32'h25f7bc60));
      test_reset_state();
      test_repeat_hit();
      test_fill_and_evict();
      test_hit_spares_way();
      test_back_to_back();
      test_random_traffic();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/set_state_ram.sv
hdl/addr_decode.sv
hdl/tag_lookup.sv
hdl/replacement_policy.sv
hdl/cache_directory.sv
tests/cache_directory_tb.sv

// ==== Bender.yml ====
package:
  name: cache_directory

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cache_pkg.sv
      - hdl/set_state_ram.sv
      - hdl/addr_decode.sv
      - hdl/tag_lookup.sv
      - hdl/replacement_policy.sv
      - hdl/cache_directory.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/cache_directory_tb.sv
